// File: verilog/rv_isa_pkg.sv
// RV32I base instruction encodings: major opcodes, funct3 and funct7
// values, and the instruction word seen in each of the six formats.
package rv_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [6:0] opc_op       = 7'b0110011;
  localparam logic [6:0] opc_op_imm   = 7'b0010011;
  localparam logic [6:0] opc_lui      = 7'b0110111;
  localparam logic [6:0] opc_auipc    = 7'b0010111;
  localparam logic [6:0] opc_jal      = 7'b1101111;
  localparam logic [6:0] opc_jalr     = 7'b1100111;
  localparam logic [6:0] opc_branch   = 7'b1100011;
  localparam logic [6:0] opc_load     = 7'b0000011;
  localparam logic [6:0] opc_store    = 7'b0100011;
  localparam logic [6:0] opc_misc_mem = 7'b0001111;
  localparam logic [6:0] opc_system   = 7'b1110011;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // funct3 and funct7 values
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shared by OP and OP-IMM.
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sh  = 3'b001;
  localparam logic [2:0] f3_sw  = 3'b010;

  localparam logic [2:0] f3_jalr  = 3'b000;
  localparam logic [2:0] f3_fence = 3'b000;

  localparam logic [6:0] f7_base = 7'h00;
  localparam logic [6:0] f7_alt  = 7'h20;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction formats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  // The B and J forms scatter their immediate bits; bit 0 is implied.
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  typedef union packed {
    rv_r_fmt_t r_fmt;
    rv_i_fmt_t i_fmt;
    rv_s_fmt_t s_fmt;
    rv_b_fmt_t b_fmt;
    rv_u_fmt_t u_fmt;
    rv_j_fmt_t j_fmt;
  } rv_instr_u;

endpackage : rv_isa_pkg

// File: verilog/id_pipe_pkg.sv
// Decode pipeline types: operation enums and their widths, and the
// fetch, control and execute bundles.
package id_pipe_pkg;

  localparam int alu_op_width = 4;
  localparam int lsu_op_width = 4;
  localparam int br_op_width  = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operation encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pass_b forwards operand b unchanged, which is how LUI writes rd.
  typedef enum logic [alu_op_width-1:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [lsu_op_width-1:0] {
    lsu_lb,
    lsu_lh,
    lsu_lw,
    lsu_lbu,
    lsu_lhu,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_e;

  // br_none must stay at zero so a reset bundle carries no branch.
  typedef enum logic [br_op_width-1:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu,
    br_jal,
    br_jalr
  } br_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [31:0] instr;
    logic [31:1] pc;
    logic [4:0]  rd_addr;
    logic        comp;
    logic        br;
    logic        br_ataken;
    logic        illegal;
  } id_fetch_t;

  typedef struct packed {
    logic    alu;
    alu_op_e alu_op;
    logic    lsu;
    lsu_op_e lsu_op;
    br_op_e  br_op;
    logic    use_imm;
    logic    use_pc;
    logic    rd_en;
    logic    illegal;
  } id_ctl_t;

  typedef struct packed {
    logic [31:1] pc;
    logic        comp;
    logic        br;
    logic        br_ataken;
    logic        use_imm;
    logic        use_pc;
    logic [31:0] imm;
    logic        illegal;
    logic        alu;
    alu_op_e     alu_op;
    logic [4:0]  rd_addr;
    logic        lsu;
    lsu_op_e     lsu_op;
    br_op_e      br_op;
    logic        rd_en;
  } id_exec_t;

endpackage : id_pipe_pkg

// File: verilog/id_ctl_decode.sv
// Control decoder for RV32I: ALU, load/store and branch operations,
// operand selects, register write enable and illegal detection.
module id_ctl_decode
  import rv_isa_pkg::*;
  import id_pipe_pkg::*;
(
  input  rv_instr_u instr,
  output id_ctl_t   ctl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_is_base;
  logic       f7_is_alt;
  logic       bad;

  // OP and OP-IMM share one funct3 map; alt selects sub or sra.
  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      f3_add_sub: op = alt ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode     = instr.r_fmt.opcode;
  assign funct3     = instr.r_fmt.funct3;
  assign funct7     = instr.r_fmt.funct7;
  assign f7_is_base = (funct7 == f7_base);
  assign f7_is_alt  = (funct7 == f7_alt);

  always_comb begin
    ctl = '0;
    bad = 1'b0;
    case (opcode)
      opc_op: begin
        ctl.alu    = 1'b1;
        ctl.rd_en  = 1'b1;
        ctl.alu_op = alu_from_f3(funct3, f7_is_alt);
        // Only add/sub and srl/sra have an alternate form.
        bad = !(f7_is_base ||
                (f7_is_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra)));
      end
      opc_op_imm: begin
        ctl.alu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.rd_en   = 1'b1;
        ctl.alu_op  = alu_from_f3(funct3, f7_is_alt && (funct3 == f3_srl_sra));
        // Shift amounts are 5 bits, so the upper bits act as a funct7.
        if (funct3 == f3_sll) begin
          bad = !f7_is_base;
        end else if (funct3 == f3_srl_sra) begin
          bad = !(f7_is_base || f7_is_alt);
        end
      end
      opc_lui: begin
        ctl.alu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.rd_en   = 1'b1;
        ctl.alu_op  = alu_pass_b;
      end
      opc_auipc: begin
        ctl.alu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.use_pc  = 1'b1;
        ctl.rd_en   = 1'b1;
        ctl.alu_op  = alu_add;
      end
      opc_jal: begin
        ctl.alu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.use_pc  = 1'b1;
        ctl.rd_en   = 1'b1;
        ctl.alu_op  = alu_add;
        ctl.br_op   = br_jal;
      end
      opc_jalr: begin
        ctl.alu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.use_pc  = 1'b1;
        ctl.rd_en   = 1'b1;
        ctl.alu_op  = alu_add;
        ctl.br_op   = br_jalr;
        bad         = (funct3 != f3_jalr);
      end
      opc_branch: begin
        ctl.use_imm = 1'b1;
        case (funct3)
          f3_beq:  ctl.br_op = br_beq;
          f3_bne:  ctl.br_op = br_bne;
          f3_blt:  ctl.br_op = br_blt;
          f3_bge:  ctl.br_op = br_bge;
          f3_bltu: ctl.br_op = br_bltu;
          f3_bgeu: ctl.br_op = br_bgeu;
          default: bad = 1'b1;
        endcase
      end
      opc_load: begin
        ctl.lsu     = 1'b1;
        ctl.use_imm = 1'b1;
        ctl.rd_en   = 1'b1;
        case (funct3)
          f3_lb:   ctl.lsu_op = lsu_lb;
          f3_lh:   ctl.lsu_op = lsu_lh;
          f3_lw:   ctl.lsu_op = lsu_lw;
          f3_lbu:  ctl.lsu_op = lsu_lbu;
          f3_lhu:  ctl.lsu_op = lsu_lhu;
          default: bad = 1'b1;
        endcase
      end
      opc_store: begin
        ctl.lsu     = 1'b1;
        ctl.use_imm = 1'b1;
        case (funct3)
          f3_sb:   ctl.lsu_op = lsu_sb;
          f3_sh:   ctl.lsu_op = lsu_sh;
          f3_sw:   ctl.lsu_op = lsu_sw;
          default: bad = 1'b1;
        endcase
      end
      // FENCE is a no-op in an in-order core with a single memory port.
      opc_misc_mem: bad = (funct3 != f3_fence);
      // There is no CSR unit, so every SYSTEM word traps.
      opc_system:   bad = 1'b1;
      default:      bad = 1'b1;
    endcase

    if (bad) begin
      ctl         = '0;
      ctl.illegal = 1'b1;
    end
  end

endmodule : id_ctl_decode

// File: verilog/id_imm_gen.sv
// Immediate generator: picks the format from the opcode and builds the
// sign-extended 32-bit immediate.
module id_imm_gen
  import rv_isa_pkg::*;
(
  input  rv_instr_u   instr,
  output logic [31:0] imm
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-format assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};

  assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}},
                  instr.s_fmt.imm_11_5,
                  instr.s_fmt.imm_4_0};

  assign imm_b = {{19{instr.b_fmt.imm_12}},
                  instr.b_fmt.imm_12,
                  instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5,
                  instr.b_fmt.imm_4_1,
                  1'b0};

  assign imm_u = {instr.u_fmt.imm_31_12, 12'h000};

  assign imm_j = {{11{instr.j_fmt.imm_20}},
                  instr.j_fmt.imm_20,
                  instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11,
                  instr.j_fmt.imm_10_1,
                  1'b0};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Format select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Opcodes without an immediate give zero, so exec sees a clean value.
  always_comb begin
    case (instr.r_fmt.opcode)
      opc_op_imm,
      opc_load,
      opc_jalr: begin
        imm = imm_i;
      end
      opc_store: begin
        imm = imm_s;
      end
      opc_branch: begin
        imm = imm_b;
      end
      opc_lui,
      opc_auipc: begin
        imm = imm_u;
      end
      opc_jal: begin
        imm = imm_j;
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule : id_imm_gen

// File: verilog/id_stage.sv
// Second decode stage: control decoder and immediate generator side by
// side, illegal merge, flush, and the registered execute bundle.
module id_stage
  import id_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      flush,
  input  id_fetch_t fetch,
  output id_exec_t  exec
);

  id_ctl_t     ctl;
  logic [31:0] imm;
  id_exec_t    exec_next;

  // Both blocks see the same word through its format views.
  id_ctl_decode u_ctl_decode (
    .instr(fetch.instr),
    .ctl  (ctl)
  );

  id_imm_gen u_imm_gen (
    .instr(fetch.instr),
    .imm  (imm)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bundle assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    exec_next.pc        = fetch.pc;
    exec_next.comp      = fetch.comp;
    exec_next.br        = fetch.br;
    exec_next.br_ataken = fetch.br_ataken;
    exec_next.rd_addr   = fetch.rd_addr;
    exec_next.use_imm   = ctl.use_imm;
    exec_next.use_pc    = ctl.use_pc;
    exec_next.imm       = imm;
    exec_next.alu       = ctl.alu;
    exec_next.alu_op    = ctl.alu_op;
    exec_next.lsu       = ctl.lsu;
    exec_next.lsu_op    = ctl.lsu_op;
    exec_next.br_op     = ctl.br_op;
    exec_next.rd_en     = ctl.rd_en;
    exec_next.illegal   = ctl.illegal | fetch.illegal;

    // A fetch fault means the word itself is garbage; nothing may execute.
    if (fetch.illegal) begin
      exec_next.alu   = 1'b0;
      exec_next.lsu   = 1'b0;
      exec_next.rd_en = 1'b0;
      exec_next.br_op = br_none;
    end

    // Flush turns the slot into a bubble; data fields are left as they are.
    if (flush) begin
      exec_next.alu       = 1'b0;
      exec_next.lsu       = 1'b0;
      exec_next.rd_en     = 1'b0;
      exec_next.br        = 1'b0;
      exec_next.br_ataken = 1'b0;
      exec_next.illegal   = 1'b0;
      exec_next.br_op     = br_none;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec <= '0;
    end else begin
      exec <= exec_next;
    end
  end

endmodule : id_stage

// File: include/id_ref_model.svh
// Reference model of the decode stage: expected execute bundle for one
// fetch word and flush level. Expects both packages to be imported.
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

function automatic id_exec_t id_ref_model(input id_fetch_t f, input logic flush);
  id_exec_t    e;
  logic [31:0] w;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        bad;
  alu_op_e     alu_tbl [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                               alu_xor, alu_srl, alu_or, alu_and};
  lsu_op_e     ld_tbl [8] = '{lsu_lb, lsu_lh, lsu_lw, lsu_lb,
                              lsu_lbu, lsu_lhu, lsu_lb, lsu_lb};
  br_op_e      br_tbl [8] = '{br_beq, br_bne, br_none, br_none,
                              br_blt, br_bge, br_bltu, br_bgeu};

  w   = f.instr;
  f3  = w[14:12];
  f7  = w[31:25];
  bad = 1'b0;
  e   = '0;
  e.pc        = f.pc;
  e.comp      = f.comp;
  e.br        = f.br;
  e.br_ataken = f.br_ataken;
  e.rd_addr   = f.rd_addr;

  case (w[6:0])
    opc_op: begin
      {e.alu, e.rd_en} = 2'b11;
      e.alu_op = alu_tbl[f3];
      if (f7 == f7_alt && f3 == 3'd0) e.alu_op = alu_sub;
      else if (f7 == f7_alt && f3 == 3'd5) e.alu_op = alu_sra;
      else if (f7 != f7_base) bad = 1'b1;
    end
    opc_op_imm: begin
      {e.alu, e.use_imm, e.rd_en} = 3'b111;
      e.alu_op = alu_tbl[f3];
      e.imm    = {{20{w[31]}}, w[31:20]};
      if (f3 == 3'd1 && f7 != f7_base) bad = 1'b1;
      if (f3 == 3'd5 && f7 == f7_alt) e.alu_op = alu_sra;
      else if (f3 == 3'd5 && f7 != f7_base) bad = 1'b1;
    end
    opc_lui, opc_auipc: begin
      {e.alu, e.use_imm, e.rd_en} = 3'b111;
      e.use_pc = (w[6:0] == opc_auipc);
      e.alu_op = e.use_pc ? alu_add : alu_pass_b;
      e.imm    = {w[31:12], 12'h000};
    end
    opc_jal, opc_jalr: begin
      {e.alu, e.use_imm, e.use_pc, e.rd_en} = 4'b1111;
      e.br_op = (w[6:0] == opc_jal) ? br_jal : br_jalr;
      e.imm   = (w[6:0] == opc_jal) ?
                {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0} : {{20{w[31]}}, w[31:20]};
      bad     = (w[6:0] == opc_jalr) && (f3 != 3'd0);
    end
    opc_branch: begin
      e.use_imm = 1'b1;
      e.br_op   = br_tbl[f3];
      e.imm     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      bad       = (f3 == 3'd2 || f3 == 3'd3);
    end
    opc_load: begin
      {e.lsu, e.use_imm, e.rd_en} = 3'b111;
      e.lsu_op = ld_tbl[f3];
      e.imm    = {{20{w[31]}}, w[31:20]};
      bad      = (f3 == 3'd3 || f3 >= 3'd6);
    end
    opc_store: begin
      {e.lsu, e.use_imm} = 2'b11;
      e.lsu_op = (f3 == 3'd0) ? lsu_sb : (f3 == 3'd1) ? lsu_sh : lsu_sw;
      e.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
      bad      = (f3 > 3'd2);
    end
    opc_misc_mem: bad = (f3 != 3'd0);
    default:      bad = 1'b1;
  endcase

  if (bad) begin
    {e.alu, e.lsu, e.rd_en, e.use_imm, e.use_pc} = '0;
    e.alu_op  = alu_add;
    e.lsu_op  = lsu_lb;
    e.br_op   = br_none;
    e.illegal = 1'b1;
  end
  if (f.illegal) begin
    {e.alu, e.lsu, e.rd_en, e.illegal} = 4'b0001;
    e.br_op = br_none;
  end
  if (flush) begin
    {e.alu, e.lsu, e.rd_en, e.br, e.br_ataken, e.illegal} = '0;
    e.br_op = br_none;
  end
  return e;
endfunction

`endif

// File: tests/tb_id_stage.sv
// Decode stage testbench with clock and reset, random instruction
// stimulus in four phases and a compare process against the reference model.
module tb_id_stage
  import rv_isa_pkg::*;
  import id_pipe_pkg::*;
();

  `include "id_ref_model.svh"

  // Reset plus four phases of 600 words is about 2410 cycles.
  localparam int words_per_phase = 600;
  localparam int max_cycles      = 3000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      flush;
  id_fetch_t fetch;
  id_exec_t  exec;

  id_exec_t exp_bundle;
  string    test_name;
  string    exp_test;
  string    phase_name [4] = '{"alu_classes", "mem_flow", "illegal_noop", "mixed"};
  int       ctl_errs;
  int       imm_errs;
  int       pass_errs;
  int       checks;
  int       cycles;

  id_stage DUT (
    .clk  (clk),
    .rst_n(rst_n),
    .flush(flush),
    .fetch(fetch),
    .exec (exec)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Classes 0-3 are ALU, 4-8 memory and control flow, 9-11 illegal or no-op.
  function automatic logic [31:0] make_word(input int phase);
    logic [31:0] w;
    int          cls;
    logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    w = $urandom;
    if ($urandom_range(7) == 0) return w;
    case (phase)
      0:       cls = int'($urandom_range(3));
      1:       cls = 4 + int'($urandom_range(4));
      2:       cls = 9 + int'($urandom_range(2));
      default: cls = int'($urandom_range(11));
    endcase
    case (cls)
      0: begin
        w[6:0]   = opc_op;
        w[31:25] = w[30] ? f7_alt : f7_base;
      end
      1: begin
        w[6:0] = opc_op_imm;
        if (w[13:12] == 2'b01) w[31:25] = w[30] ? f7_alt : f7_base;
      end
      2: w[6:0] = opc_lui;
      3: w[6:0] = opc_auipc;
      4: begin
        w[6:0]   = opc_load;
        w[14:12] = ld_f3[$urandom_range(4)];
      end
      5: begin
        w[6:0]   = opc_store;
        w[14:12] = 3'($urandom_range(2));
      end
      6: begin
        w[6:0]   = opc_branch;
        w[14:12] = br_f3[$urandom_range(5)];
      end
      7: w[6:0] = opc_jal;
      8: begin
        w[6:0]   = opc_jalr;
        w[14:12] = f3_jalr;
      end
      9: begin
        // Reserved encodings of otherwise valid opcodes.
        case ($urandom_range(2))
          0: begin
            w[6:0]  = opc_branch;
            w[14:13] = 2'b01;
          end
          1: begin
            w[6:0] = opc_op;
            w[31]  = 1'b1;
          end
          default: begin
            w[6:0]   = opc_load;
            w[14:12] = 3'b011;
          end
        endcase
      end
      10: w[6:0] = opc_system;
      default: begin
        w[6:0]   = opc_misc_mem;
        w[14:12] = f3_fence;
      end
    endcase
    return w;
  endfunction

  function automatic id_fetch_t make_fetch(input int phase);
    id_fetch_t f;
    f.instr     = make_word(phase);
    f.pc        = 31'($urandom);
    f.rd_addr   = 5'($urandom);
    f.comp      = 1'($urandom_range(1));
    f.br        = 1'($urandom_range(1));
    f.br_ataken = 1'($urandom_range(1));
    f.illegal   = ($urandom_range(15) == 0);
    return f;
  endfunction

  initial begin
    void'($urandom(89));
    rst_n     = 1'b0;
    flush     = 1'b0;
    fetch     = '0;
    test_name = "reset";
    // Random words during reset must not leak into exec.
    repeat (10) begin
      @(posedge clk);
      fetch <= make_fetch(3);
    end
    rst_n <= 1'b1;
    for (int p = 0; p < 4; p++) begin
      repeat (words_per_phase) begin
        @(posedge clk);
        fetch     <= make_fetch(p);
        flush     <= ($urandom_range(9) == 0);
        test_name = phase_name[p];
      end
    end
    // The last word is compared on the falling edge after it registers.
    @(posedge clk);
    @(posedge clk);
    $display("errors: control %0d, immediate %0d, pass-through %0d (%0d cycles checked)",
             ctl_errs, imm_errs, pass_errs, checks);
    if (ctl_errs + imm_errs + pass_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [17:0] ctl_bits(input id_exec_t e);
    return {e.alu, e.alu_op, e.lsu, e.lsu_op, e.br_op, e.use_imm, e.use_pc, e.rd_en,
            e.illegal};
  endfunction

  function automatic logic [38:0] pass_bits(input id_exec_t e);
    return {e.pc, e.comp, e.br, e.br_ataken, e.rd_addr};
  endfunction

  // On the falling edge exec holds the word taken at the last rising edge,
  // and fetch already holds the word for the next one.
  always @(negedge clk) begin
    if (ctl_bits(exec) !== ctl_bits(exp_bundle)) begin
      ctl_errs++;
      $display("FAIL %s control: expected %h actual %h",
               exp_test, ctl_bits(exp_bundle), ctl_bits(exec));
    end
    if (exec.imm !== exp_bundle.imm) begin
      imm_errs++;
      $display("FAIL %s imm: expected %h actual %h", exp_test, exp_bundle.imm, exec.imm);
    end
    if (pass_bits(exec) !== pass_bits(exp_bundle)) begin
      pass_errs++;
      $display("FAIL %s pass-through: expected %h actual %h",
               exp_test, pass_bits(exp_bundle), pass_bits(exec));
    end
    if (rst_n) checks++;
    exp_bundle = rst_n ? id_ref_model(fetch, flush) : '0;
    exp_test   = !rst_n ? "reset" : flush ? {test_name, "/flush"} : test_name;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("ERROR: timeout after %0d cycles, the run did not finish", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    exp_bundle = '0;
    exp_test   = "reset";
    ctl_errs   = 0;
    imm_errs   = 0;
    pass_errs  = 0;
    checks     = 0;
    cycles     = 0;
  end

endmodule : tb_id_stage

// File: verilog.f
+incdir+include
verilog/rv_isa_pkg.sv
verilog/id_pipe_pkg.sv
verilog/id_ctl_decode.sv
verilog/id_imm_gen.sv
verilog/id_stage.sv
tests/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - files:
      - verilog/rv_isa_pkg.sv
      - verilog/id_pipe_pkg.sv
      - verilog/id_ctl_decode.sv
      - verilog/id_imm_gen.sv
      - verilog/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_id_stage.sv
